// File: io_pkg.sv
`default_nettype none

package io_pkg;

    // data path sizes
    localparam int ISA_WIDTH  = 32;            // one cpu word
    localparam int SWITCH_CNT = 16;            // toggle switches on the board
    localparam int MAX_DIGITS = 8;             // 99999999 still fits in 32 bits

    // keypad scan timing, in clock cycles
    localparam int SCAN_DWELL     = 4;         // each row held low this long
    localparam int DEBOUNCE_SCANS = 3;         // full rounds a key must stay stable

    // display multiplexing
    localparam int DISP_DWELL = 16;            // cycles per lit digit

    // seven segment bundle, both fields active low
    // seg bit order is {dp, g, f, e, d, c, b, a}
    typedef struct packed {
        logic [7:0] an;                        // digit anodes, bit 0 is the rightmost digit
        logic [7:0] seg;
    } disp_bus_t;

endpackage

`default_nettype wire

// File: key_pkg.sv
`default_nettype none

package key_pkg;

    // keypad codes are {row, col}, each nibble one-cold
    // row 0 is the top row, col 0 the leftmost column
    typedef enum logic [7:0] {
        KEY_1         = 8'b1110_1110,
        KEY_2         = 8'b1110_1101,
        KEY_3         = 8'b1110_1011,
        KEY_PAUSE     = 8'b1110_0111,   // "A" halts and resumes the cpu
        KEY_4         = 8'b1101_1110,
        KEY_5         = 8'b1101_1101,
        KEY_6         = 8'b1101_1011,
        KEY_TOGGLE    = 8'b1101_0111,   // "B" swaps keypad and switch entry
        KEY_7         = 8'b1011_1110,
        KEY_8         = 8'b1011_1101,
        KEY_9         = 8'b1011_1011,
        KEY_C         = 8'b1011_0111,   // spare
        KEY_BACKSPACE = 8'b0111_1110,   // "*"
        KEY_0         = 8'b0111_1101,
        KEY_ENTER     = 8'b0111_1011,   // "#"
        KEY_D         = 8'b0111_0111    // spare
    } key_code_t;

    // one debounced press, valid lasts a single cycle
    typedef struct packed {
        logic      valid;
        key_code_t code;
    } key_event_t;

    typedef enum logic [1:0] {
        ST_BLOCK,      // waiting for the cpu to ask for a value
        ST_SWITCH,     // value comes from the toggle switches
        ST_KEYPAD,     // building a decimal number from keys
        ST_HALT        // cpu paused until resumed
    } input_state_t;

endpackage

`default_nettype wire

// File: keypad_scanner.sv
`default_nettype none

module keypad_scanner (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [3:0]          kp_col,
    output logic [3:0]          kp_row,
    output key_pkg::key_event_t key_event
);
    import io_pkg::*;
    import key_pkg::*;

    localparam int DWELL_W = $clog2(SCAN_DWELL);
    localparam int DEB_W   = $clog2(DEBOUNCE_SCANS + 1);

    localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(SCAN_DWELL - 1);
    localparam logic [DEB_W-1:0]   DEB_TARGET = DEB_W'(DEBOUNCE_SCANS);

    logic [DWELL_W-1:0] dwell_cnt;
    logic [3:0]         col_meta;
    logic [3:0]         col_sync;
    logic               sample;
    logic               round_end;
    logic               col_hit;
    logic [3:0]         col_pick;

    logic               cand_hit;      // a key was already seen this round
    logic [7:0]         cand_code;
    logic               round_hit;
    logic [7:0]         round_code;
    logic [7:0]         last_code;     // code of the previous round

    logic [DEB_W-1:0]   press_cnt;
    logic [DEB_W-1:0]   press_next;
    logic [DEB_W-1:0]   release_cnt;
    logic               armed;         // high once the pad has been released
    logic               event_valid;
    key_code_t          event_code;

    // lowest low column wins when several keys share a row
    function automatic logic [3:0] first_low(input logic [3:0] col);
        logic [3:0] pick;
        pick = 4'hF;
        for (int i = 3; i >= 0; i--) begin
            if (!col[i])
                pick = ~(4'b0001 << i);
        end
        return pick;
    endfunction

    assign sample    = (dwell_cnt == DWELL_LAST);   // last cycle of the row dwell
    assign round_end = sample && (kp_row == 4'b0111);
    assign col_hit   = (col_sync != 4'hF);
    assign col_pick  = first_low(col_sync);

    // the earlier row in the round takes priority
    assign round_hit  = cand_hit | col_hit;
    assign round_code = cand_hit ? cand_code : {kp_row, col_pick};

    always_comb begin
        if (round_code != last_code)
            press_next = DEB_W'(1);
        else if (press_cnt == DEB_TARGET)
            press_next = press_cnt;                   // saturate while held
        else
            press_next = press_cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            kp_row    <= 4'b1110;
            col_meta  <= 4'hF;
            col_sync  <= 4'hF;
        end else begin
            col_meta <= kp_col;                       // columns are asynchronous pins
            col_sync <= col_meta;
            if (sample) begin
                dwell_cnt <= '0;
                kp_row    <= {kp_row[2:0], kp_row[3]};
            end else begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cand_hit    <= 1'b0;
            press_cnt   <= '0;
            release_cnt <= '0;
            armed       <= 1'b1;
            event_valid <= 1'b0;
        end else begin
            event_valid <= 1'b0;
            if (round_end) begin
                cand_hit <= 1'b0;
                if (round_hit) begin
                    release_cnt <= '0;
                    press_cnt   <= press_next;
                    if (armed && press_next == DEB_TARGET) begin
                        event_valid <= 1'b1;
                        armed       <= 1'b0;
                    end
                end else begin
                    press_cnt <= '0;
                    if (release_cnt != DEB_TARGET)
                        release_cnt <= release_cnt + 1'b1;
                    if (release_cnt + 1'b1 >= DEB_TARGET)
                        armed <= 1'b1;
                end
            end else if (sample && col_hit && !cand_hit) begin
                cand_hit <= 1'b1;
            end
        end
    end

    // code registers, meaningful only alongside the flags above
    always_ff @(posedge clk) begin
        if (round_end) begin
            last_code  <= round_code;
            event_code <= key_code_t'(round_code);
        end else if (sample && col_hit && !cand_hit) begin
            cand_code <= {kp_row, col_pick};
        end
    end

    assign key_event = '{valid: event_valid, code: event_code};

endmodule

`default_nettype wire

// File: input_unit.sv
`default_nettype none

module input_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  key_pkg::key_event_t           key_event,
    input  logic [io_pkg::SWITCH_CNT-1:0] switch_map,
    input  logic                          input_enable,    // data memory wants a value
    input  logic                          uart_complete,   // upload finished, resume allowed
    output logic                          input_complete,  // enter or pause seen
    output logic                          switch_enable,
    output logic                          cpu_pause,
    output logic                          overflow,        // extra digits were dropped
    output logic [io_pkg::ISA_WIDTH-1:0]  input_data
);
    import io_pkg::*;
    import key_pkg::*;

    localparam int CNT_W = $clog2(MAX_DIGITS + 1);
    localparam logic [CNT_W-1:0] DIGIT_LIMIT = CNT_W'(MAX_DIGITS);

    input_state_t         state;
    logic [ISA_WIDTH-1:0] value_q;       // decimal accumulator
    logic [CNT_W-1:0]     digit_cnt;
    logic [4:0]           digit_dec;
    logic                 is_digit;
    logic [3:0]           digit_val;
    logic                 pause_hit;
    logic [ISA_WIDTH-1:0] value_x10;

    // {is_digit, digit}
    function automatic logic [4:0] decode_digit(input key_code_t code);
        case (code)
            KEY_0:   return {1'b1, 4'd0};
            KEY_1:   return {1'b1, 4'd1};
            KEY_2:   return {1'b1, 4'd2};
            KEY_3:   return {1'b1, 4'd3};
            KEY_4:   return {1'b1, 4'd4};
            KEY_5:   return {1'b1, 4'd5};
            KEY_6:   return {1'b1, 4'd6};
            KEY_7:   return {1'b1, 4'd7};
            KEY_8:   return {1'b1, 4'd8};
            KEY_9:   return {1'b1, 4'd9};
            default: return 5'b0_0000;
        endcase
    endfunction

    assign digit_dec = decode_digit(key_event.code);
    assign is_digit  = digit_dec[4];
    assign digit_val = digit_dec[3:0];
    assign pause_hit = key_event.valid && (key_event.code == KEY_PAUSE);

    assign value_x10 = (value_q << 3) + (value_q << 1);   // 8x + 2x

    assign switch_enable = (state == ST_SWITCH);
    assign input_data    = switch_enable ? ISA_WIDTH'(switch_map) : value_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_BLOCK;
            value_q        <= '0;
            digit_cnt      <= '0;
            input_complete <= 1'b0;
            cpu_pause      <= 1'b0;
            overflow       <= 1'b0;
        end else begin
            case (state)
                ST_BLOCK: begin
                    if (pause_hit) begin
                        state     <= ST_HALT;
                        cpu_pause <= 1'b1;
                    end else if (input_enable) begin
                        // fresh request, start from an empty number
                        state          <= ST_KEYPAD;
                        value_q        <= '0;
                        digit_cnt      <= '0;
                        overflow       <= 1'b0;
                        input_complete <= 1'b0;
                    end
                end

                ST_KEYPAD: begin
                    if (!input_enable) begin
                        state <= ST_BLOCK;             // request withdrawn
                    end else if (key_event.valid) begin
                        case (key_event.code)
                            KEY_ENTER: begin
                                state          <= ST_BLOCK;
                                input_complete <= 1'b1;
                            end
                            KEY_PAUSE: begin
                                state          <= ST_HALT;
                                input_complete <= 1'b1;
                                cpu_pause      <= 1'b1;
                            end
                            KEY_TOGGLE: begin
                                state <= ST_SWITCH;
                            end
                            KEY_BACKSPACE: begin
                                if (digit_cnt != '0) begin
                                    value_q   <= value_q / ISA_WIDTH'(10);
                                    digit_cnt <= digit_cnt - 1'b1;
                                end
                            end
                            default: begin
                                if (is_digit) begin
                                    if (digit_cnt < DIGIT_LIMIT) begin
                                        value_q   <= value_x10 + ISA_WIDTH'(digit_val);
                                        digit_cnt <= digit_cnt + 1'b1;
                                    end else begin
                                        overflow <= 1'b1;
                                    end
                                end
                            end
                        endcase
                    end
                end

                ST_SWITCH: begin
                    if (key_event.valid) begin
                        case (key_event.code)
                            KEY_TOGGLE: state <= ST_KEYPAD;
                            KEY_ENTER: begin
                                state          <= ST_BLOCK;
                                input_complete <= 1'b1;
                            end
                            KEY_PAUSE: begin
                                state          <= ST_HALT;
                                input_complete <= 1'b1;
                                cpu_pause      <= 1'b1;
                            end
                            default: state <= ST_SWITCH;   // digits ignored here
                        endcase
                    end
                end

                ST_HALT: begin
                    // resume only once the upload is done
                    if (pause_hit && uart_complete) begin
                        state     <= ST_BLOCK;
                        cpu_pause <= 1'b0;
                    end
                end

                default: state <= ST_BLOCK;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: seven_seg_unit.sv
`default_nettype none

module seven_seg_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [io_pkg::ISA_WIDTH-1:0] value,
    output io_pkg::disp_bus_t            disp
);
    import io_pkg::*;

    localparam int DWELL_W = $clog2(DISP_DWELL);
    localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(DISP_DWELL - 1);

    logic [DWELL_W-1:0] dwell_cnt;
    logic [2:0]         digit_idx;     // eight digits, one nibble each
    logic [2:0]         digit_next;
    logic [7:0]         an_q;
    logic [3:0]         nibble;
    logic [6:0]         seg_on;        // active high gfedcba

    assign digit_next = (dwell_cnt == DWELL_LAST) ? digit_idx + 1'b1 : digit_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            digit_idx <= '0;
            an_q      <= 8'hFF;                 // blank while in reset
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
            digit_idx <= digit_next;
            an_q      <= ~(8'b0000_0001 << digit_next);
        end
    end

    assign nibble = value[digit_idx*4 +: 4];

    always_comb begin
        case (nibble)
            4'h0: seg_on = 7'h3F;
            4'h1: seg_on = 7'h06;
            4'h2: seg_on = 7'h5B;
            4'h3: seg_on = 7'h4F;
            4'h4: seg_on = 7'h66;
            4'h5: seg_on = 7'h6D;
            4'h6: seg_on = 7'h7D;
            4'h7: seg_on = 7'h07;
            4'h8: seg_on = 7'h7F;
            4'h9: seg_on = 7'h6F;
            4'hA: seg_on = 7'h77;
            4'hB: seg_on = 7'h7C;           // lower case b
            4'hC: seg_on = 7'h39;
            4'hD: seg_on = 7'h5E;           // lower case d
            4'hE: seg_on = 7'h79;
            default: seg_on = 7'h71;        // F
        endcase
    end

    // decimal point stays dark
    assign disp = '{an: an_q, seg: {1'b1, ~seg_on}};

endmodule

`default_nettype wire

// File: input_top.sv
`default_nettype none

module input_top (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [3:0]                    kp_row,          // active low
    input  logic [3:0]                    kp_col,          // active low, pulled up
    input  logic [io_pkg::SWITCH_CNT-1:0] switch_map,
    input  logic                          input_enable,
    input  logic                          uart_complete,
    output logic                          input_complete,
    output logic [io_pkg::ISA_WIDTH-1:0]  input_data,
    output logic                          switch_enable,
    output logic                          cpu_pause,
    output logic                          overflow,
    output io_pkg::disp_bus_t             disp
);
    import key_pkg::*;

    key_event_t key_event;

    keypad_scanner u_scanner (
        .clk       (clk),
        .rst_n     (rst_n),
        .kp_col    (kp_col),
        .kp_row    (kp_row),
        .key_event (key_event)
    );

    input_unit u_input (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_event      (key_event),
        .switch_map     (switch_map),
        .input_enable   (input_enable),
        .uart_complete  (uart_complete),
        .input_complete (input_complete),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .overflow       (overflow),
        .input_data     (input_data)
    );

    seven_seg_unit u_display (
        .clk   (clk),
        .rst_n (rst_n),
        .value (input_data),
        .disp  (disp)
    );

endmodule

`default_nettype wire

// File: tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 4;     // 8 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: input_assertions.sv
`default_nettype none

module input_assertions (
    input logic                                    clk,
    input logic                                    rst_n,
    input key_pkg::key_event_t                     key_event,
    input key_pkg::input_state_t                   state,
    input logic [io_pkg::ISA_WIDTH-1:0]            value_q,
    input logic [$clog2(io_pkg::MAX_DIGITS+1)-1:0] digit_cnt,
    input logic                                    input_enable,
    input logic [io_pkg::SWITCH_CNT-1:0]           switch_map,
    input logic [io_pkg::ISA_WIDTH-1:0]            input_data,
    input logic                                    input_complete,
    input logic                                    cpu_pause
);
    timeunit 1ns;
    timeprecision 100ps;

    import io_pkg::*;
    import key_pkg::*;

    int unsigned fail_cnt = 0;
    int          digit_now;     // -1 for keys that are not digits
    logic        in_keypad;     // keypad state with the request still open

    // digit from the key position on the pad, rows 1-2-3 / 4-5-6 / 7-8-9, 0 under 8
    function automatic int digit_of(input logic [7:0] code);
        int r;
        int c;
        r = -1;
        c = -1;
        for (int i = 0; i < 4; i++) begin
            if (!code[4+i]) r = i;
            if (!code[i]) c = i;
        end
        if (r >= 0 && r < 3 && c >= 0 && c < 3)
            return 3 * r + c + 1;
        if (r == 3 && c == 1)
            return 0;
        return -1;
    endfunction

    assign digit_now = digit_of(key_event.code);
    assign in_keypad = (state == ST_KEYPAD) && input_enable;

    digit_append: assert property (@(posedge clk) disable iff (!rst_n)
        key_event.valid && in_keypad && digit_now >= 0 && digit_cnt < MAX_DIGITS
        |=> value_q == $past(value_q) * 10 + ISA_WIDTH'($past(digit_now)))
        else begin
            $error("digit did not give the old value times ten plus the digit");
            fail_cnt++;
        end

    backspace_divide: assert property (@(posedge clk) disable iff (!rst_n)
        key_event.valid && in_keypad && key_event.code == KEY_BACKSPACE
        |=> value_q == $past(value_q) / 10)
        else begin
            $error("backspace did not divide the value by ten");
            fail_cnt++;
        end

    enter_completes: assert property (@(posedge clk) disable iff (!rst_n)
        key_event.valid && key_event.code == KEY_ENTER && (in_keypad || state == ST_SWITCH)
        |=> input_complete && state == ST_BLOCK)
        else begin
            $error("enter did not complete the input and return to the blocked state");
            fail_cnt++;
        end

    pause_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_pause |-> state == ST_HALT)
        else begin
            $error("cpu_pause is high outside the halt state");
            fail_cnt++;
        end

    switch_passthrough: assert property (@(posedge clk) disable iff (!rst_n)
        state == ST_SWITCH |-> input_data == ISA_WIDTH'(switch_map))
        else begin
            $error("input_data does not follow the switches");
            fail_cnt++;
        end

endmodule

bind input_unit input_assertions u_checks (
    .clk            (clk),
    .rst_n          (rst_n),
    .key_event      (key_event),
    .state          (state),
    .value_q        (value_q),
    .digit_cnt      (digit_cnt),
    .input_enable   (input_enable),
    .switch_map     (switch_map),
    .input_data     (input_data),
    .input_complete (input_complete),
    .cpu_pause      (cpu_pause)
);

`default_nettype wire

// File: input_tb.sv
`default_nettype none

module input_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import io_pkg::*;
    import key_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int ROUND_CYCLES = 4 * SCAN_DWELL;
    // one partial round on press plus the column synchronizer
    localparam int HOLD_CYCLES  = (DEBOUNCE_SCANS + 2) * ROUND_CYCLES;
    localparam int PRESS_CYCLES = 2 * HOLD_CYCLES;                  // held, then released
    localparam int PRESS_COUNT  = 8 + 19 + 5 + 4 + 8;               // presses over all tests
    localparam int WATCHDOG_CYCLES = PRESS_COUNT * PRESS_CYCLES * 5 / 4 + 8 * DISP_DWELL + 200;

    logic                  clk;
    logic                  rst_n;
    logic [3:0]            kp_row;
    logic [3:0]            kp_col = 4'hF;
    logic [SWITCH_CNT-1:0] switch_map;
    logic                  input_enable;
    logic                  uart_complete;
    logic                  input_complete;
    logic [ISA_WIDTH-1:0]  input_data;
    logic                  switch_enable;
    logic                  cpu_pause;
    logic                  overflow;
    disp_bus_t             disp;

    logic                  key_down = 1'b0;
    key_code_t             key_sel = KEY_D;
    int                    seed = 32'h833c4702;
    int                    errors = 0;
    int                    failed_tests = 0;
    int                    errors_before;
    int unsigned           assert_before = 0;
    logic [ISA_WIDTH-1:0]  exp_value;
    int                    exp_digits;
    logic                  exp_overflow;

    key_code_t  digit_key [10] = '{KEY_0, KEY_1, KEY_2, KEY_3, KEY_4,
                                   KEY_5, KEY_6, KEY_7, KEY_8, KEY_9};
    logic [6:0] hex_seg [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                                 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};  // gfedcba

    tb_clock u_clock (.clk(clk));

    input_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .kp_row         (kp_row),
        .kp_col         (kp_col),
        .switch_map     (switch_map),
        .input_enable   (input_enable),
        .uart_complete  (uart_complete),
        .input_complete (input_complete),
        .input_data     (input_data),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .overflow       (overflow),
        .disp           (disp)
    );

    // keypad switch matrix, the held key shorts its column to its row
    always @(negedge clk)
        kp_col <= (key_down && kp_row == key_sel[7:4]) ? key_sel[3:0] : 4'hF;

    function automatic int random_digit();
        return int'($unsigned($random(seed)) % 10);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error: %s is %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic press_key(input key_code_t code);
        logic seen;
        seen = 1'b0;
        key_sel  <= code;
        key_down <= 1'b1;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            if (DUT.key_event.valid)
                seen = 1'b1;
            if (input_complete)
                input_enable = 1'b0;      // cpu withdraws the request once served
        end
        key_down <= 1'b0;
        repeat (HOLD_CYCLES) @(negedge clk);
        if (!seen) begin
            $display("key %s was held but the scanner gave no key event", code.name());
            errors++;
        end
    endtask

    task automatic start_entry();
        input_enable = 1'b0;
        @(negedge clk);                   // drops an open keypad entry
        input_enable = 1'b1;
        @(negedge clk);
        exp_value    = '0;
        exp_digits   = 0;
        exp_overflow = 1'b0;
    endtask

    task automatic type_digit(input int d);
        press_key(digit_key[d]);
        if (exp_digits < MAX_DIGITS) begin
            exp_value = exp_value * 10 + ISA_WIDTH'(d);
            exp_digits++;
        end else begin
            exp_overflow = 1'b1;
        end
    endtask

    task automatic type_backspace();
        press_key(KEY_BACKSPACE);
        if (exp_digits > 0) begin
            exp_value = exp_value / 10;
            exp_digits--;
        end
    endtask

    task automatic report_test(input int num, input string name);
        int new_errors;
        new_errors = errors - errors_before
                     + int'(DUT.u_input.u_checks.fail_cnt - assert_before);
        if (new_errors == 0) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, new_errors);
            failed_tests++;
        end
        errors_before = errors;
        assert_before = DUT.u_input.u_checks.fail_cnt;
    endtask

    task automatic enter_number();
        int n;
        n = 1 + int'($unsigned($random(seed)) % 7);
        start_entry();
        repeat (n) type_digit(random_digit());
        press_key(KEY_ENTER);
        check_value("input_data", input_data, exp_value);
        check_value("input_complete", 32'(input_complete), 32'd1);
        check_value("cpu_pause", 32'(cpu_pause), 32'd0);
    endtask

    task automatic edit_number();
        start_entry();
        type_backspace();                 // nothing held yet
        repeat (3) type_digit(random_digit());
        type_backspace();
        type_digit(random_digit());
        repeat (4) type_backspace();      // last one finds no digits
        repeat (MAX_DIGITS + 1) type_digit(random_digit());
        check_value("input_data", input_data, exp_value);
        check_value("overflow", 32'(overflow), 32'(exp_overflow));
    endtask

    task automatic pass_switches();
        start_entry();
        repeat (2) type_digit(random_digit());
        press_key(KEY_TOGGLE);
        check_value("switch_enable", 32'(switch_enable), 32'd1);
        check_value("input_data", input_data, ISA_WIDTH'(switch_map));
        switch_map = SWITCH_CNT'($random(seed));
        @(negedge clk);
        check_value("input_data", input_data, ISA_WIDTH'(switch_map));
        press_key(KEY_TOGGLE);
        check_value("switch_enable", 32'(switch_enable), 32'd0);
        press_key(KEY_ENTER);
        check_value("input_data", input_data, exp_value);
        check_value("input_complete", 32'(input_complete), 32'd1);
    endtask

    task automatic pause_cpu();
        start_entry();
        type_digit(random_digit());
        press_key(KEY_PAUSE);
        check_value("cpu_pause", 32'(cpu_pause), 32'd1);
        check_value("input_complete", 32'(input_complete), 32'd1);
        press_key(KEY_PAUSE);             // upload still running
        check_value("cpu_pause", 32'(cpu_pause), 32'd1);
        uart_complete = 1'b1;
        press_key(KEY_PAUSE);
        check_value("cpu_pause", 32'(cpu_pause), 32'd0);
        uart_complete = 1'b0;
    endtask

    task automatic scan_display();
        int         idx;
        logic [7:0] lit_seen;
        start_entry();
        repeat (MAX_DIGITS) type_digit(random_digit());
        lit_seen = '0;
        repeat (8 * DISP_DWELL) begin
            @(negedge clk);
            if ($countones(~disp.an) != 1) begin
                $display("display lit %0d digits at once", $countones(~disp.an));
                errors++;
            end else begin
                idx = 0;
                for (int i = 0; i < 8; i++)
                    if (!disp.an[i]) idx = i;
                lit_seen[idx] = 1'b1;
                check_value("disp.seg", 32'(disp.seg),
                            32'({1'b1, ~hex_seg[exp_value[idx*4 +: 4]]}));
            end
        end
        if (lit_seen != 8'hFF) begin
            $display("display skipped a digit during a full round");
            errors++;
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        switch_map    = SWITCH_CNT'($random(seed));
        input_enable  = 1'b0;
        uart_complete = 1'b0;
        errors_before = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        enter_number();
        report_test(1, "entry");
        edit_number();
        report_test(2, "editing");
        pass_switches();
        report_test(3, "switches");
        pause_cpu();
        report_test(4, "pause");
        scan_display();
        report_test(5, "display");

        $display("tests run 5, failed %0d, check errors %0d, assertion failures %0d",
                 failed_tests, errors, DUT.u_input.u_checks.fail_cnt);
        if (failed_tests == 0 && DUT.u_input.u_checks.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run stopped, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
io_pkg.sv
key_pkg.sv
keypad_scanner.sv
input_unit.sv
seven_seg_unit.sv
input_top.sv
tb_clock.sv
input_assertions.sv
input_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module input_tb -f filelist.f
	./obj_dir/Vinput_tb +verilator+error+limit+100 | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
